// File: Makefile
TOOL    = verilator
FLAGS   = --binary --timing --assert -j 0
TOP     = tb_multi_sampler
FLIST   = multi_sampler.f
OBJ_DIR = obj_dir
PASS    = TB PASSED

.PHONY: all compile run clean

all: run

# Build the simulation executable from the file list
compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR) -o $(TOP)

# Run from the project root so the vector file path resolves
run: compile
	@out="$$(./$(OBJ_DIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS)$$"

clean:
	rm -rf $(OBJ_DIR)

// File: bench/sampler_golden.txt
# Vectors for the multi sampler bench, one test per line, decimal except the hex enable mask
# Columns: name base div0 div1 div2 en mode run chg_at new_base pulses cnt0 cnt1 cnt2
# mode 0 holds ext_trig high for run cycles, mode 1 draws it at random each cycle
# chg_at gives the cycle where the base period becomes new_base, with 0 for no change
# A count of -1 is left to the bench, which derives it from its own trigger and pulse counts
base_div3      3  1  2  4  7  0   20   0  0    7    7   3   1
base_div5      5  2  3  5  7  0   37   0  0    8    4   2   1
enable_zero    2  3  4  0  5  0   24   0  0   12    4   0   0
zero_base      0  2  3  5  7  0   12   0  0   12    6   4   2
rand_trig_a    3  1  2  3  7  1   60   0  0   -1   -1  -1  -1
rand_trig_b    7  1  3  0  3  1  100   0  0   -1   -1  -1  -1
period_change  4  1  2  3  7  0   30  10  3   10   10   5   3
rand_change    5  2  1  4  7  1   80  40  2   -1   -1  -1  -1
clear_setup    2  1  2  3  7  0   16   0  0    8    8   4   2

// File: bench/tb_multi_sampler.sv
`timescale 1ns/100ps
`default_nettype none

`include "sampler_params.svh"

module tb_multi_sampler;
   import sampler_pkg::*;

   localparam string     GOLDEN_FILE    = "bench/sampler_golden.txt";
   localparam int        APB_TIMEOUT    = 16;       // Cycles allowed for pready
   localparam int        SETTLE_TIMEOUT = 32;       // Cycles allowed for the pipeline to drain
   localparam apb_addr_t UNMAPPED_ADDR  = 8'h3c;

   logic       clk;
   logic       arst_n;
   logic       psel;
   logic       penable;
   logic       pwrite;
   apb_addr_t  paddr;
   apb_data_t  pwdata;
   apb_data_t  prdata;
   logic       pready;
   logic       pslverr;
   logic       ext_trig;
   logic       sample_out;
   chan_mask_t dsample_stb;

   string      test_name;                           // Fields of the current vector line
   int         base;
   int         div_per [`SMP_NUM_DIV];
   int         en;
   int         mode;
   int         run_len;
   int         chg_at;
   int         new_base;
   int         exp_pulses;
   int         exp_cnt [`SMP_NUM_DIV];

   int         seed;
   int         errors;
   int         tests;
   int         failed_tests;
   int         pulse_cnt;                           // Sample pulses seen since reset
   int         stb_cnt [`SMP_NUM_DIV];              // Strobes seen per channel since reset

   multi_sampler_top DUT (
      .clk         (clk),
      .arst_n      (arst_n),
      .psel        (psel),
      .penable     (penable),
      .pwrite      (pwrite),
      .paddr       (paddr),
      .pwdata      (pwdata),
      .prdata      (prdata),
      .pready      (pready),
      .pslverr     (pslverr),
      .ext_trig    (ext_trig),
      .sample_out  (sample_out),
      .dsample_stb (dsample_stb)
   );

   always #10 clk = ~clk;                           // 20 ns period

   // Outputs are counted on the falling edge, half a cycle after they change
   always @(negedge clk) begin
      if (!arst_n) begin
         pulse_cnt = 0;
         for (int ch = 0; ch < `SMP_NUM_DIV; ch++) begin
            stb_cnt[ch] = 0;
         end
      end else begin
         if (sample_out) begin
            pulse_cnt++;
         end
         for (int ch = 0; ch < `SMP_NUM_DIV; ch++) begin
            if (((int'(dsample_stb) >> ch) & 1) != 0) begin
               stb_cnt[ch]++;
            end
         end
      end
   end

   //////////////////////////////////////////////////
   // Helpers
   //////////////////////////////////////////////////

   function automatic int pulses_for(input int trig, input int per);
      int p;
      p = (per == 0) ? 1 : per;                     // A zero period runs as a period of one
      if (trig <= 0) begin
         return 0;
      end
      return (trig + p - 1) / p;
   endfunction

   function automatic apb_addr_t reg_addr(input apb_addr_t first, input int ch);
      return apb_addr_t'(int'(first) + `SMP_REG_STRIDE * ch);
   endfunction

   task automatic check_eq(input string what, input int got, input int exp);
      if (got != exp) begin
         $display("** Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
         errors++;
      end
   endtask

   task automatic abort_run(input string why);
      $display("Run stopped at %0t ns: %s", $time, why);
      $display("TB FAILED");
      $finish;
   endtask

   task automatic reset_dut();
      @(posedge clk);
      arst_n <= 1'b0;
      repeat (4) @(posedge clk);
      arst_n <= 1'b1;
   endtask

   task automatic apb_access(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
                             output apb_data_t rdata, output logic err);
      int wait_cycles;
      @(posedge clk);
      psel    <= 1'b1;                              // Setup phase
      penable <= 1'b0;
      pwrite  <= wr;
      paddr   <= addr;
      pwdata  <= wdata;
      @(posedge clk);
      penable <= 1'b1;                              // Access phase
      wait_cycles = 0;
      @(negedge clk);
      while (!pready && wait_cycles < APB_TIMEOUT) begin
         @(negedge clk);
         wait_cycles++;
      end
      if (!pready) begin
         abort_run("APB access never saw pready");
      end else begin
         rdata = prdata;
         err   = pslverr;
         @(posedge clk);
         psel    <= 1'b0;
         penable <= 1'b0;
      end
   endtask

   task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
      apb_data_t unused;
      logic      err;
      apb_access(1'b1, addr, data, unused, err);
      check_eq($sformatf("pslverr on write to 0x%02h", addr), int'(err), 0);
   endtask

   task automatic apb_read(input apb_addr_t addr, output apb_data_t data);
      logic err;
      apb_access(1'b0, addr, '0, data, err);
      check_eq($sformatf("pslverr on read of 0x%02h", addr), int'(err), 0);
   endtask

   // Waits until neither a sample pulse nor a strobe is in flight
   task automatic settle_outputs();
      int idle_wait;
      idle_wait = 0;
      @(negedge clk);
      while ((sample_out || dsample_stb != '0) && idle_wait < SETTLE_TIMEOUT) begin
         @(negedge clk);
         idle_wait++;
      end
      if (sample_out || dsample_stb != '0) begin
         abort_run("sample_out and dsample_stb never went idle");
      end else begin
         repeat (2) @(posedge clk);                 // Counters trail the strobes by a cycle
      end
   endtask

   //////////////////////////////////////////////////
   // Tests
   //////////////////////////////////////////////////

   task automatic run_vector();
      int        i;
      int        ch;
      int        trig_cnt;
      int        trig_a;
      int        rnd;
      int        model;
      int        exp_stb;
      logic      trig_bit;
      apb_data_t rdata;
      reset_dut();
      apb_write(`SMP_REG_CTRL, '0);
      apb_write(`SMP_REG_BASE, apb_data_t'(base));
      for (ch = 0; ch < `SMP_NUM_DIV; ch++) begin
         apb_write(reg_addr(`SMP_REG_DIV0, ch), apb_data_t'(div_per[ch]));
      end
      apb_write(`SMP_REG_CLEAR, apb_data_t'((1 << `SMP_NUM_DIV) - 1));
      apb_write(`SMP_REG_CTRL, apb_data_t'(en));
      trig_cnt = 0;
      trig_a   = 0;
      for (i = 0; i < run_len; i++) begin
         if (chg_at > 0 && i == chg_at) begin
            @(posedge clk);
            ext_trig <= 1'b0;                       // Triggers pause while the period changes
            trig_a = trig_cnt;
            apb_write(`SMP_REG_BASE, apb_data_t'(new_base));
         end
         if (mode == 0) begin
            trig_bit = 1'b1;
         end else begin
            rnd      = $random(seed);
            trig_bit = rnd[0];
         end
         @(posedge clk);
         ext_trig <= trig_bit;
         if (trig_bit) begin
            trig_cnt++;
         end
      end
      @(posedge clk);
      ext_trig <= 1'b0;
      settle_outputs();
      if (chg_at > 0) begin
         // The first trigger after a change only restarts a count that was mid period
         model = pulses_for(trig_a, base);
         if (trig_a % ((base == 0) ? 1 : base) != 0) begin
            model += pulses_for(trig_cnt - trig_a - 1, new_base);
         end else begin
            model += pulses_for(trig_cnt - trig_a, new_base);
         end
      end else begin
         model = pulses_for(trig_cnt, base);
      end
      check_eq("sample pulses against trigger count", pulse_cnt, model);
      if (exp_pulses >= 0) begin
         check_eq("sample pulses against vector file", pulse_cnt, exp_pulses);
      end
      for (ch = 0; ch < `SMP_NUM_DIV; ch++) begin
         exp_stb = (((en >> ch) & 1) != 0 && div_per[ch] != 0) ? pulse_cnt / div_per[ch] : 0;
         apb_read(reg_addr(`SMP_REG_CNT0, ch), rdata);
         check_eq($sformatf("channel %0d strobes seen", ch), stb_cnt[ch], exp_stb);
         check_eq($sformatf("channel %0d counter", ch), int'(rdata), exp_stb);
         if (exp_cnt[ch] >= 0) begin
            check_eq($sformatf("channel %0d against vector file", ch), stb_cnt[ch], exp_cnt[ch]);
         end
      end
   endtask

   // Runs on the counters left by the last vector
   task automatic check_apb_errors();
      apb_data_t v0;
      apb_data_t v2;
      apb_data_t rdata;
      logic      err;
      apb_access(1'b0, UNMAPPED_ADDR, '0, rdata, err);
      check_eq("pslverr on unmapped read", int'(err), 1);
      apb_read(reg_addr(`SMP_REG_CNT0, 0), v0);
      apb_read(reg_addr(`SMP_REG_CNT0, 2), v2);
      apb_access(1'b1, reg_addr(`SMP_REG_CNT0, 0), 32'h0000_abcd, rdata, err);
      check_eq("pslverr on counter write", int'(err), 1);
      apb_read(reg_addr(`SMP_REG_CNT0, 0), rdata);
      check_eq("counter 0 after rejected write", int'(rdata), int'(v0));
      apb_write(`SMP_REG_CLEAR, 32'h0000_0002);     // Channel 1 only
      apb_read(reg_addr(`SMP_REG_CNT0, 1), rdata);
      check_eq("counter 1 after its clear", int'(rdata), 0);
      apb_read(reg_addr(`SMP_REG_CNT0, 0), rdata);
      check_eq("counter 0 after clear of 1", int'(rdata), int'(v0));
      apb_read(reg_addr(`SMP_REG_CNT0, 2), rdata);
      check_eq("counter 2 after clear of 1", int'(rdata), int'(v2));
   endtask

   task automatic finish_test(input string label, input int errors_before);
      tests++;
      if (errors != errors_before) begin
         failed_tests++;
         $display("Test %s: %0d mismatches", label, errors - errors_before);
      end else begin
         $display("Test %s: ok", label);
      end
   endtask

   initial begin
      int                 fd;
      int                 n;
      int                 errors_before;
      logic [8*160-1:0]   line;
      clk          = 1'b0;
      arst_n       = 1'b0;
      psel         = 1'b0;
      penable      = 1'b0;
      pwrite       = 1'b0;
      paddr        = '0;
      pwdata       = '0;
      ext_trig     = 1'b0;
      seed         = 32'he51e_f154;
      errors       = 0;
      tests        = 0;
      failed_tests = 0;
      fd = $fopen(GOLDEN_FILE, "r");
      if (fd == 0) begin
         abort_run("could not open the vector file");
      end else begin
         while (!$feof(fd)) begin
            line = '0;
            n = $fgets(line, fd);
            n = $sscanf(line, "%s %d %d %d %d %h %d %d %d %d %d %d %d %d",
                        test_name, base, div_per[0], div_per[1], div_per[2], en, mode,
                        run_len, chg_at, new_base, exp_pulses, exp_cnt[0], exp_cnt[1],
                        exp_cnt[2]);
            if (n == 14) begin                      // Comment and blank lines fall short
               errors_before = errors;
               run_vector();
               finish_test(test_name, errors_before);
            end
         end
         $fclose(fd);
         errors_before = errors;
         check_apb_errors();
         finish_test("apb_errors", errors_before);
         $display("Tests run %0d, tests failed %0d, mismatches %0d", tests, failed_tests,
                  errors);
         if (errors == 0 && tests > 1) begin
            $display("TB PASSED");
         end else begin
            $display("TB FAILED");
         end
         $finish;
      end
   end

endmodule

`default_nettype wire

// File: multi_sampler.f
+incdir+rtl
rtl/sampler_pkg.sv
rtl/sampler_regs.sv
rtl/base_sampler.sv
rtl/strobe_divider.sv
rtl/strobe_monitor.sv
rtl/multi_sampler_top.sv
bench/tb_multi_sampler.sv

// File: rtl/base_sampler.sv
`timescale 1ns/100ps
`default_nettype none

`include "sampler_params.svh"

module base_sampler (
   input  wire                       clk,
   input  wire                       arst_n,
   input  wire                       ext_trig,
   input  wire sampler_pkg::period_t base_period,
   output logic                      sample_pulse
);
   import sampler_pkg::*;

   period_t per_q;     // Period seen at the last trigger
   period_t count_q;   // Triggers since the last sample pulse
   period_t last_cnt;  // Terminal count of the running period

   // A period of zero runs the same as a period of one
   assign last_cnt = (base_period == '0) ? '0 : base_period - 1'b1;

   //////////////////////////////////////////////////
   // Trigger counting
   //////////////////////////////////////////////////

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         per_q        <= '0;
         count_q      <= '0;
         sample_pulse <= 1'b0;
      end else begin
         sample_pulse <= 1'b0;
         if (ext_trig) begin
            per_q        <= base_period;
            sample_pulse <= (count_q == '0);          // Pulse on the trigger at count zero
            if ((base_period != per_q) && (count_q != '0)) begin
               count_q <= '0;                         // Restart on a period change
            end else if (count_q >= last_cnt) begin
               count_q <= '0;
            end else begin
               count_q <= count_q + 1'b1;
            end
         end
      end
   end

   // Back-to-back pulses only happen when the period in force is 1 or 0.
   // per_q in the first pulse cycle holds the period used by that trigger
   a_no_double_pulse: assert property (
      @(posedge clk) disable iff (!arst_n)
      (sample_pulse && (per_q > period_t'(1))) |=> !sample_pulse
   );

endmodule

`default_nettype wire

// File: rtl/multi_sampler_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "sampler_params.svh"

module multi_sampler_top (
   input  wire                          clk,
   input  wire                          arst_n,
   input  wire                          psel,
   input  wire                          penable,
   input  wire                          pwrite,
   input  wire sampler_pkg::apb_addr_t  paddr,
   input  wire sampler_pkg::apb_data_t  pwdata,
   output sampler_pkg::apb_data_t       prdata,
   output logic                         pready,
   output logic                         pslverr,
   input  wire                          ext_trig,
   output logic                         sample_out,
   output sampler_pkg::chan_mask_t      dsample_stb
);
   import sampler_pkg::*;

   period_t       base_period;
   period_t       div_period [`SMP_NUM_DIV];
   chan_mask_t    div_en;
   chan_mask_t    clear_mask;
   strobe_count_t counts [`SMP_NUM_DIV];

   sampler_regs u_regs (
      .clk         (clk),
      .arst_n      (arst_n),
      .psel        (psel),
      .penable     (penable),
      .pwrite      (pwrite),
      .paddr       (paddr),
      .pwdata      (pwdata),
      .prdata      (prdata),
      .pready      (pready),
      .pslverr     (pslverr),
      .counts      (counts),
      .base_period (base_period),
      .div_period  (div_period),
      .div_en      (div_en),
      .clear_mask  (clear_mask)
   );

   base_sampler u_base (
      .clk          (clk),
      .arst_n       (arst_n),
      .ext_trig     (ext_trig),
      .base_period  (base_period),
      .sample_pulse (sample_out)                      // Also feeds every divider
   );

   for (genvar i = 0; i < `SMP_NUM_DIV; i++) begin : g_div
      strobe_divider u_div (
         .clk          (clk),
         .arst_n       (arst_n),
         .sample_pulse (sample_out),
         .enable       (div_en[i]),
         .div_period   (div_period[i]),
         .strobe       (dsample_stb[i])
      );
   end

   strobe_monitor u_mon (
      .clk        (clk),
      .arst_n     (arst_n),
      .strobe     (dsample_stb),
      .clear_mask (clear_mask),
      .counts     (counts)
   );

endmodule

`default_nettype wire

// File: rtl/sampler_params.svh
`ifndef SAMPLER_PARAMS_SVH
`define SAMPLER_PARAMS_SVH

//////////////////////////////////////////////////
// Sizes
//////////////////////////////////////////////////

`define SMP_NUM_DIV     3        // Strobe dividers behind the base sampler
`define SMP_PERIOD_W    16       // Base and divider period width
`define SMP_COUNT_W     16       // Width of each strobe event counter
`define SMP_ADDR_W      8        // APB address width
`define SMP_DATA_W      32       // APB data width

//////////////////////////////////////////////////
// APB register map
//////////////////////////////////////////////////

`define SMP_REG_CTRL    8'h00    // Divider enables in the low bits
`define SMP_REG_BASE    8'h04    // Base sample period
`define SMP_REG_DIV0    8'h08    // First divider period
`define SMP_REG_CNT0    8'h20    // First strobe counter, read only
`define SMP_REG_CLEAR   8'h40    // Write ones to clear the selected counters
`define SMP_REG_STRIDE  4        // Byte step between per-channel registers

`endif

// File: rtl/sampler_pkg.sv
`default_nettype none

`include "sampler_params.svh"

package sampler_pkg;

   // Period of the base sampler or of one divider
   typedef logic [`SMP_PERIOD_W-1:0] period_t;

   // Number of strobes seen on one channel
   typedef logic [`SMP_COUNT_W-1:0]  strobe_count_t;

   // APB address and data words
   typedef logic [`SMP_ADDR_W-1:0]   apb_addr_t;
   typedef logic [`SMP_DATA_W-1:0]   apb_data_t;

   // One bit per divider channel
   typedef logic [`SMP_NUM_DIV-1:0]  chan_mask_t;

endpackage

`default_nettype wire

// File: rtl/sampler_regs.sv
`timescale 1ns/100ps
`default_nettype none

`include "sampler_params.svh"

module sampler_regs (
   input  wire                          clk,
   input  wire                          arst_n,
   input  wire                          psel,
   input  wire                          penable,
   input  wire                          pwrite,
   input  wire sampler_pkg::apb_addr_t  paddr,
   input  wire sampler_pkg::apb_data_t  pwdata,
   output sampler_pkg::apb_data_t       prdata,
   output logic                         pready,
   output logic                         pslverr,
   input  wire sampler_pkg::strobe_count_t counts [`SMP_NUM_DIV],
   output sampler_pkg::period_t         base_period,
   output sampler_pkg::period_t         div_period [`SMP_NUM_DIV],
   output sampler_pkg::chan_mask_t      div_en,
   output sampler_pkg::chan_mask_t      clear_mask
);
   import sampler_pkg::*;

   logic      access;     // Access phase of a transfer
   logic      wr_en;
   logic      rd_en;
   logic      addr_hit;   // Address maps to some register
   logic      cnt_hit;    // Address is one of the read-only counters
   apb_data_t rdata;

   assign access = psel & penable;
   assign wr_en  = access & pwrite;
   assign rd_en  = access & ~pwrite;
   assign pready = 1'b1;                              // Zero wait states

   //////////////////////////////////////////////////
   // Address decode and read mux
   //////////////////////////////////////////////////

   always_comb begin
      rdata    = '0;
      addr_hit = 1'b0;
      cnt_hit  = 1'b0;
      if (paddr == `SMP_REG_CTRL) begin
         rdata    = apb_data_t'(div_en);
         addr_hit = 1'b1;
      end
      if (paddr == `SMP_REG_BASE) begin
         rdata    = apb_data_t'(base_period);
         addr_hit = 1'b1;
      end
      if (paddr == `SMP_REG_CLEAR) begin
         addr_hit = 1'b1;                             // Reads back as zero
      end
      for (int i = 0; i < `SMP_NUM_DIV; i++) begin
         if (paddr == `SMP_REG_DIV0 + apb_addr_t'(`SMP_REG_STRIDE * i)) begin
            rdata    = apb_data_t'(div_period[i]);
            addr_hit = 1'b1;
         end
         if (paddr == `SMP_REG_CNT0 + apb_addr_t'(`SMP_REG_STRIDE * i)) begin
            rdata    = apb_data_t'(counts[i]);
            addr_hit = 1'b1;
            cnt_hit  = 1'b1;
         end
      end
   end

   assign prdata  = rd_en ? rdata : '0;
   assign pslverr = access & (~addr_hit | (pwrite & cnt_hit));

   //////////////////////////////////////////////////
   // Register writes
   //////////////////////////////////////////////////

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         div_en      <= '0;
         base_period <= '0;                           // Behaves as a period of 1
         clear_mask  <= '0;
         for (int i = 0; i < `SMP_NUM_DIV; i++) begin
            div_period[i] <= '0;                      // No strobes until programmed
         end
      end else begin
         clear_mask <= '0;                            // Clear is a single-cycle pulse
         if (wr_en) begin
            if (paddr == `SMP_REG_CTRL) begin
               div_en <= pwdata[`SMP_NUM_DIV-1:0];
            end
            if (paddr == `SMP_REG_BASE) begin
               base_period <= pwdata[`SMP_PERIOD_W-1:0];
            end
            if (paddr == `SMP_REG_CLEAR) begin
               clear_mask <= pwdata[`SMP_NUM_DIV-1:0];
            end
            for (int i = 0; i < `SMP_NUM_DIV; i++) begin
               if (paddr == `SMP_REG_DIV0 + apb_addr_t'(`SMP_REG_STRIDE * i)) begin
                  div_period[i] <= pwdata[`SMP_PERIOD_W-1:0];
               end
            end
         end
      end
   end

   // The access phase is always entered from a selected setup phase
   a_penable_needs_psel: assert property (
      @(posedge clk) disable iff (!arst_n) $rose(penable) |-> psel
   );

endmodule

`default_nettype wire

// File: rtl/strobe_divider.sv
`timescale 1ns/100ps
`default_nettype none

`include "sampler_params.svh"

module strobe_divider (
   input  wire                       clk,
   input  wire                       arst_n,
   input  wire                       sample_pulse,
   input  wire                       enable,
   input  wire sampler_pkg::period_t div_period,
   output logic                      strobe
);
   import sampler_pkg::*;

   period_t count_q;   // Pulses left to the next strobe, zero means reload
   period_t remain;    // Pulses left, counting the reload value

   assign remain = (count_q == '0) ? div_period : count_q;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         count_q <= '0;
         strobe  <= 1'b0;
      end else begin
         strobe <= 1'b0;
         if (!enable) begin
            count_q <= '0;                            // Parked in the reload state
         end else if (sample_pulse) begin
            if (remain == period_t'(1)) begin
               strobe  <= 1'b1;                       // Nth pulse reached
               count_q <= '0;
            end else if (remain != '0) begin
               count_q <= remain - 1'b1;
            end
         end
      end
   end

   // After a strobe the count restarts from div_period, so a strobe in the
   // very next cycle is only possible when that period is 1
   a_strobe_spacing: assert property (
      @(posedge clk) disable iff (!arst_n)
      (strobe && (div_period != period_t'(1))) |=> !strobe
   );

endmodule

`default_nettype wire

// File: rtl/strobe_monitor.sv
`timescale 1ns/100ps
`default_nettype none

`include "sampler_params.svh"

module strobe_monitor (
   input  wire                          clk,
   input  wire                          arst_n,
   input  wire sampler_pkg::chan_mask_t strobe,
   input  wire sampler_pkg::chan_mask_t clear_mask,
   output sampler_pkg::strobe_count_t   counts [`SMP_NUM_DIV]
);
   import sampler_pkg::*;

   localparam strobe_count_t COUNT_MAX = '1;   // Counters stick here

   //////////////////////////////////////////////////
   // One saturating counter per channel
   //////////////////////////////////////////////////

   for (genvar ch = 0; ch < `SMP_NUM_DIV; ch++) begin : g_chan
      always_ff @(posedge clk or negedge arst_n) begin
         if (!arst_n) begin
            counts[ch] <= '0;
         end else if (clear_mask[ch]) begin
            counts[ch] <= '0;                         // Clear wins over a new strobe
         end else if (strobe[ch] && (counts[ch] != COUNT_MAX)) begin
            counts[ch] <= counts[ch] + 1'b1;
         end
      end
   end

endmodule

`default_nettype wire
